/* rtl/isa_pkg.sv */
package isa_pkg;

    // Instruction field widths
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    // Standard RV32I opcodes
    localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_REG    = 7'b0110011;

    // Custom interrupt and interface opcodes
    localparam logic [OPCODE_W-1:0] OP_RTI = 7'b0001000;
    localparam logic [OPCODE_W-1:0] OP_RDI = 7'b0001010;
    localparam logic [OPCODE_W-1:0] OP_SND = 7'b0001011;
    localparam logic [OPCODE_W-1:0] OP_UAD = 7'b0101011;

    // System word that stops fetch
    localparam logic [31:0] INSN_HALT = 32'h00000073;

    // funct3 values for ALU and branch instructions
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;
    localparam logic [FUNCT3_W-1:0] F3_BEQ     = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE     = 3'b001;

    localparam logic [FUNCT7_W-1:0] F7_SUB = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

endpackage

/* rtl/pipe_pkg.sv */
package pipe_pkg;
    import isa_pkg::*;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC   = 32'h0;
    localparam logic [XLEN-1:0] IRQ_VECTOR = 32'h200;

    // IF/ID register contents
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } fetch_t;

    // ID/EX register contents
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_t               alu_op;
        logic                  alu_src_imm;
        logic                  reg_write;
        logic                  branch;
        logic                  branch_ne;
        logic                  jal;
        logic                  rti;
        logic                  rdi;
        logic                  snd;
        logic                  uad;
        logic                  halt;
    } dec_ex_t;

endpackage

/* rtl/irq_if.sv */
`timescale 1ns/1ps

interface irq_if import pipe_pkg::*; ();

    logic            request;
    logic [XLEN-1:0] source_data;
    logic            accept;
    logic            ret;

    modport ctrl (
        output request,
        output source_data,
        input  accept,
        input  ret
    );

    modport execute (
        input  request,
        input  source_data,
        output accept,
        output ret
    );

endinterface

/* rtl/fetch.sv */
`timescale 1ns/1ps

module fetch import pipe_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [31:0]     instr,
    input  logic            redirect_valid,
    input  logic [XLEN-1:0] redirect_pc,
    input  logic            halt_seen,
    output logic [XLEN-1:0] pc,
    output fetch_t          if_id,
    output logic            halted
);

    logic [XLEN-1:0] pc_next;

    always_comb begin
        if (redirect_valid) begin
            pc_next = redirect_pc;
        end else if (halted) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= RESET_PC;
            halted <= 1'b0;
        end else begin
            pc <= pc_next;
            // Sticky until the next reset
            if (halt_seen) begin
                halted <= 1'b1;
            end
        end
    end

    // Instruction arrives in the same cycle as pc
    always_ff @(posedge clk) begin
        if_id.pc    <= pc;
        if_id.instr <= instr;
        if (!rst_n) begin
            if_id.valid <= 1'b0;
        end else begin
            // Wrong-path word dropped on redirect and nothing issued after halt
            if_id.valid <= !redirect_valid && !halted;
        end
    end

endmodule

/* rtl/decode.sv */
`timescale 1ns/1ps

module decode import isa_pkg::*; import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fetch_t                if_id,
    input  logic                  flush,
    input  logic                  wb_en,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic [XLEN-1:0]       wb_data,
    output dec_ex_t               id_ex
);

    logic [XLEN-1:0] regs [32];

    logic [OPCODE_W-1:0]   opcode;
    logic [FUNCT3_W-1:0]   funct3;
    logic [FUNCT7_W-1:0]   funct7;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_b;
    logic [XLEN-1:0]       imm_u;
    logic [XLEN-1:0]       imm_j;
    dec_ex_t               dec;

    assign opcode = if_id.instr[6:0];
    assign funct3 = if_id.instr[14:12];
    assign funct7 = if_id.instr[31:25];
    assign rs1    = if_id.instr[19:15];
    assign rs2    = if_id.instr[24:20];

    assign imm_i = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
    assign imm_b = {{20{if_id.instr[31]}}, if_id.instr[7], if_id.instr[30:25],
                    if_id.instr[11:8], 1'b0};
    assign imm_u = {if_id.instr[31:12], 12'b0};
    assign imm_j = {{12{if_id.instr[31]}}, if_id.instr[19:12], if_id.instr[20],
                    if_id.instr[30:21], 1'b0};

    // r0 is never written
    always_ff @(posedge clk) begin
        if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_comb begin
        dec             = '0;
        dec.valid       = if_id.valid;
        dec.pc          = if_id.pc;
        dec.rd          = if_id.instr[11:7];
        dec.alu_op      = ALU_ADD;

        // Write-through covers the instruction currently in EX
        if (rs1 == '0) begin
            dec.rs1_val = '0;
        end else if (wb_en && wb_rd == rs1) begin
            dec.rs1_val = wb_data;
        end else begin
            dec.rs1_val = regs[rs1];
        end

        if (rs2 == '0) begin
            dec.rs2_val = '0;
        end else if (wb_en && wb_rd == rs2) begin
            dec.rs2_val = wb_data;
        end else begin
            dec.rs2_val = regs[rs2];
        end

        case (opcode)
            OP_REG: begin
                dec.reg_write = 1'b1;
                case (funct3)
                    F3_ADD_SUB: dec.alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT:     dec.alu_op = ALU_SLT;
                    F3_XOR:     dec.alu_op = ALU_XOR;
                    F3_OR:      dec.alu_op = ALU_OR;
                    F3_AND:     dec.alu_op = ALU_AND;
                    default:    dec.reg_write = 1'b0;
                endcase
            end
            OP_IMM: begin
                dec.reg_write   = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec.imm         = imm_i;
                case (funct3)
                    F3_ADD_SUB: dec.alu_op = ALU_ADD;
                    F3_XOR:     dec.alu_op = ALU_XOR;
                    F3_OR:      dec.alu_op = ALU_OR;
                    F3_AND:     dec.alu_op = ALU_AND;
                    default:    dec.reg_write = 1'b0;
                endcase
            end
            OP_LUI: begin
                dec.reg_write   = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec.imm         = imm_u;
                dec.alu_op      = ALU_PASS_B;
            end
            OP_BRANCH: begin
                dec.imm       = imm_b;
                dec.branch    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                dec.branch_ne = (funct3 == F3_BNE);
            end
            OP_JAL: begin
                dec.imm       = imm_j;
                dec.jal       = 1'b1;
                dec.reg_write = 1'b1;
            end
            OP_RTI: dec.rti = 1'b1;
            OP_RDI: begin
                dec.rdi       = 1'b1;
                dec.reg_write = 1'b1;
            end
            OP_SND: dec.snd = 1'b1;
            OP_UAD: dec.uad = 1'b1;
            default: dec.halt = (if_id.instr == INSN_HALT);
        endcase
    end

    always_ff @(posedge clk) begin
        id_ex <= dec;
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else if (flush) begin
            id_ex.valid <= 1'b0;
        end
    end

endmodule

/* rtl/execute.sv */
`timescale 1ns/1ps

module execute import isa_pkg::*; import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  dec_ex_t               id_ex,
    irq_if.execute                irq,
    output logic                  wb_en,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data,
    output logic                  redirect_valid,
    output logic [XLEN-1:0]       redirect_pc,
    output logic                  halt_seen,
    output logic                  snd,
    output logic                  uad,
    output logic [XLEN-1:0]       interface_data
);

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] saved_pc;
    logic            taken;

    assign op_b     = id_ex.alu_src_imm ? id_ex.imm : id_ex.rs2_val;
    assign pc_plus4 = id_ex.pc + 32'd4;
    assign target   = id_ex.pc + id_ex.imm;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_result = id_ex.rs1_val + op_b;
            ALU_SUB:    alu_result = id_ex.rs1_val - op_b;
            ALU_AND:    alu_result = id_ex.rs1_val & op_b;
            ALU_OR:     alu_result = id_ex.rs1_val | op_b;
            ALU_XOR:    alu_result = id_ex.rs1_val ^ op_b;
            ALU_SLT:    alu_result = {31'b0, $signed(id_ex.rs1_val) < $signed(op_b)};
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // BNE inverts the equality test
    assign taken = id_ex.valid && (id_ex.jal || (id_ex.branch &&
                   ((id_ex.rs1_val == id_ex.rs2_val) ^ id_ex.branch_ne)));

    assign wb_en   = id_ex.valid && id_ex.reg_write && id_ex.rd != '0;
    assign wb_rd   = id_ex.rd;
    assign wb_data = id_ex.jal ? pc_plus4 : (id_ex.rdi ? irq.source_data : alu_result);

    assign halt_seen = id_ex.valid && id_ex.halt;

    // Halt word never takes an interrupt
    assign irq.accept = irq.request && id_ex.valid && !id_ex.halt;
    assign irq.ret    = id_ex.valid && id_ex.rti;

    always_comb begin
        redirect_valid = 1'b1;
        if (irq.accept) begin
            redirect_pc = IRQ_VECTOR;
        end else if (taken) begin
            redirect_pc = target;
        end else if (irq.ret) begin
            redirect_pc = saved_pc;
        end else begin
            // Halt parks fetch on the halt word and kills younger stages
            redirect_pc    = id_ex.pc;
            redirect_valid = halt_seen;
        end
    end

    // Return address is where the leaving instruction would go next
    always_ff @(posedge clk) begin
        if (irq.accept) begin
            saved_pc <= taken ? target : pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            snd <= 1'b0;
            uad <= 1'b0;
        end else begin
            snd <= id_ex.valid && id_ex.snd;
            uad <= id_ex.valid && id_ex.uad;
        end
    end

    always_ff @(posedge clk) begin
        if (id_ex.valid && (id_ex.snd || id_ex.uad)) begin
            interface_data <= id_ex.rs1_val;
        end
    end

endmodule

/* rtl/interrupt_ctrl.sv */
`timescale 1ns/1ps

module interrupt_ctrl import pipe_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            interrupt_key,
    input  logic            interrupt_eth,
    input  logic [XLEN-1:0] interrupt_source_data,
    irq_if.ctrl             irq
);

    // Set from accept until RTI to block nested requests
    logic nest_latch;
    logic raise;

    assign raise = (interrupt_key || interrupt_eth) && !nest_latch && !irq.request;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq.request <= 1'b0;
            nest_latch  <= 1'b0;
        end else begin
            if (irq.accept) begin
                irq.request <= 1'b0;
                nest_latch  <= 1'b1;
            end else if (raise) begin
                irq.request <= 1'b1;
            end
            if (irq.ret) begin
                nest_latch <= 1'b0;
            end
        end
    end

    // Data captured once per request
    always_ff @(posedge clk) begin
        if (raise) begin
            irq.source_data <= interrupt_source_data;
        end
    end

endmodule

/* rtl/proc.sv */
`timescale 1ns/1ps

module proc import pipe_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [31:0]     instr,
    input  logic            interrupt_key,
    input  logic            interrupt_eth,
    input  logic [XLEN-1:0] interrupt_source_data,
    output logic [XLEN-1:0] pc,
    output logic            snd,
    output logic            uad,
    output logic [XLEN-1:0] interface_data,
    output logic            halted
);

    fetch_t                if_id;
    dec_ex_t               id_ex;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic                  redirect_valid;
    logic [XLEN-1:0]       redirect_pc;
    logic                  halt_seen;

    irq_if irq_bus ();

    fetch i_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr          (instr),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .halt_seen      (halt_seen),
        .pc             (pc),
        .if_id          (if_id),
        .halted         (halted)
    );

    // Redirect also squashes the instruction being decoded
    decode i_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .if_id   (if_id),
        .flush   (redirect_valid),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .id_ex   (id_ex)
    );

    execute i_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_ex          (id_ex),
        .irq            (irq_bus.execute),
        .wb_en          (wb_en),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .halt_seen      (halt_seen),
        .snd            (snd),
        .uad            (uad),
        .interface_data (interface_data)
    );

    interrupt_ctrl i_interrupt_ctrl (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .interrupt_key         (interrupt_key),
        .interrupt_eth         (interrupt_eth),
        .interrupt_source_data (interrupt_source_data),
        .irq                   (irq_bus.ctrl)
    );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held low for the first 8 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* testbench/tb_proc.sv */
`timescale 1ns/1ps

module tb_proc import isa_pkg::*; import pipe_pkg::*; ();

    localparam int INIT_WORDS = 27;
    localparam int BODY_WORDS = 64;
    localparam int HALT_IDX   = INIT_WORDS + BODY_WORDS;
    localparam int MAX_IRQ    = 6;
    localparam int LIMIT      = 20 * (HALT_IDX + 4) + 200 * MAX_IRQ;

    logic            clk;
    logic            rst_n;
    logic [31:0]     instr;
    logic            interrupt_key;
    logic            interrupt_eth;
    logic [XLEN-1:0] interrupt_source_data;
    logic [XLEN-1:0] pc;
    logic            snd;
    logic            uad;
    logic [XLEN-1:0] interface_data;
    logic            halted;

    logic [31:0] imem [256];
    logic [31:0] model_regs [32];
    logic [31:0] snd_expect [$];
    logic [31:0] uad_expect [$];
    integer      seed = 32'h106f;
    int          data_errors;
    int          other_errors;
    int          snd_total;
    int          snd_seen;
    int          irq_count;

    tb_clock i_clock (.clk(clk), .rst_n(rst_n));

    proc i_dut (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .instr                 (instr),
        .interrupt_key         (interrupt_key),
        .interrupt_eth         (interrupt_eth),
        .interrupt_source_data (interrupt_source_data),
        .pc                    (pc),
        .snd                   (snd),
        .uad                   (uad),
        .interface_data        (interface_data),
        .halted                (halted)
    );

    // Instruction memory answers pc in the same cycle
    assign instr = imem[pc[9:2]];

    function automatic int unsigned rnd(int unsigned n);
        rnd = $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [4:0] pick_reg();
        pick_reg = 5'(1 + rnd(27));
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        enc_i = {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2,
                                          logic [4:0] rs1, logic [2:0] f3);
        enc_b = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
        enc_j = {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    task automatic build_program();
        logic [2:0] f3_r [5];
        logic [2:0] f3_i [4];
        int         skip;
        int         kind;
        f3_r = '{F3_ADD_SUB, F3_SLT, F3_XOR, F3_OR, F3_AND};
        f3_i = '{F3_ADD_SUB, F3_XOR, F3_OR, F3_AND};
        // Harmless ADDI r0 filler with the word address as immediate
        for (int a = 0; a < 256; a++) begin
            imem[a] = enc_i(12'(a * 4), 5'd0, F3_ADD_SUB, 5'd0);
        end
        for (int i = 0; i < INIT_WORDS; i++) begin
            imem[i] = enc_i(12'(rnd(4096)), 5'd0, F3_ADD_SUB, 5'(i + 1));
        end
        for (int i = INIT_WORDS; i < HALT_IDX; i++) begin
            skip = rnd(4);
            if (i + 1 + skip > HALT_IDX) begin
                skip = HALT_IDX - i - 1;
            end
            kind = rnd(10);
            case (kind)
                0, 1: imem[i] = {(rnd(2) != 0) ? F7_SUB : 7'b0, pick_reg(), pick_reg(),
                                 f3_r[rnd(5)], pick_reg(), OP_REG};
                2, 3: imem[i] = enc_i(12'(rnd(4096)), pick_reg(), f3_i[rnd(4)], pick_reg());
                4:    imem[i] = {20'(rnd(1 << 20)), pick_reg(), OP_LUI};
                5:    imem[i] = enc_b(13'(4 * (skip + 1)), pick_reg(), pick_reg(),
                                      (rnd(2) != 0) ? F3_BNE : F3_BEQ);
                6:    imem[i] = enc_j(21'(4 * (skip + 1)), pick_reg());
                default: imem[i] = {12'b0, pick_reg(), 3'b0, 5'b0, OP_SND};
            endcase
        end
        imem[HALT_IDX] = INSN_HALT;
        // Interrupt handler reads the data into r31, sends it and returns
        imem[IRQ_VECTOR[9:2]]     = {20'b0, 5'd31, OP_RDI};
        imem[IRQ_VECTOR[9:2] + 1] = {12'b0, 5'd31, 3'b0, 5'b0, OP_UAD};
        imem[IRQ_VECTOR[9:2] + 2] = {25'b0, OP_RTI};
    endtask

    // ISA-level model of the main program
    task automatic run_model();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] mpc;
        logic [4:0]  rd;
        logic        wr;
        mpc = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int step = 0; step < 1000; step++) begin
            w = imem[mpc[9:2]];
            if (w == INSN_HALT) begin
                break;
            end
            rd  = w[11:7];
            a   = model_regs[w[19:15]];
            b   = model_regs[w[24:20]];
            wr  = 1'b0;
            res = '0;
            if (w[6:0] == OP_IMM) begin
                b = {{20{w[31]}}, w[31:20]};
            end
            case (w[6:0])
                OP_REG, OP_IMM: begin
                    wr = 1'b1;
                    case (w[14:12])
                        3'b000: res = (w[6:0] == OP_REG && w[31:25] == F7_SUB) ? a - b : a + b;
                        3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b100: res = a ^ b;
                        3'b110: res = a | b;
                        default: res = a & b;
                    endcase
                end
                OP_LUI: begin
                    wr  = 1'b1;
                    res = {w[31:12], 12'b0};
                end
                OP_SND: snd_expect.push_back(a);
                default: ;
            endcase
            if (w[6:0] == OP_JAL) begin
                wr  = 1'b1;
                res = mpc + 4;
                mpc = mpc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end else if (w[6:0] == OP_BRANCH && ((a == b) ^ (w[14:12] == F3_BNE))) begin
                mpc = mpc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end else begin
                mpc = mpc + 4;
            end
            if (wr && rd != 0) begin
                model_regs[rd] = res;
            end
        end
        snd_total = snd_expect.size();
    endtask

    // Scoreboard on the send outputs
    always @(posedge clk) begin
        if (rst_n) begin
            if ((snd || uad) && halted) begin
                $display("Error at %0t: send pulse after halt", $time);
                other_errors++;
            end
            if (snd) begin
                snd_seen++;
                if (snd_expect.size() == 0) begin
                    $display("Error at %0t: more snd pulses than expected", $time);
                    other_errors++;
                end else begin
                    if (interface_data !== snd_expect[0]) begin
                        $display("Fail %0t: snd data %h expected %h", $time,
                                 interface_data, snd_expect[0]);
                        data_errors++;
                    end
                    void'(snd_expect.pop_front());
                end
            end
            if (uad) begin
                if (uad_expect.size() == 0) begin
                    $display("Error at %0t: unexpected uad pulse", $time);
                    other_errors++;
                end else begin
                    if (interface_data !== uad_expect[0]) begin
                        $display("Fail %0t: uad data %h expected %h", $time,
                                 interface_data, uad_expect[0]);
                        data_errors++;
                    end
                    void'(uad_expect.pop_front());
                end
            end
        end
    end

    task automatic fire_interrupt();
        logic [31:0] data;
        int          waited;
        data = $random(seed);
        uad_expect.push_back(data);
        irq_count++;
        interrupt_source_data <= data;
        if (rnd(2) != 0) begin
            interrupt_key <= 1'b1;
        end else begin
            interrupt_eth <= 1'b1;
        end
        @(posedge clk);
        interrupt_key <= 1'b0;
        interrupt_eth <= 1'b0;
        // Second request while the first is unserved must be dropped
        if (rnd(2) != 0) begin
            @(posedge clk);
            interrupt_source_data <= $random(seed);
            interrupt_key         <= 1'b1;
            interrupt_eth         <= (rnd(2) != 0);
            @(posedge clk);
            interrupt_key <= 1'b0;
            interrupt_eth <= 1'b0;
        end
        waited = 0;
        while (!uad && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        if (!uad) begin
            $display("Error at %0t: interrupt was never served", $time);
            other_errors++;
        end
    endtask

    initial begin
        interrupt_key         = 1'b0;
        interrupt_eth         = 1'b0;
        interrupt_source_data = '0;
        build_program();
        run_model();
        @(posedge rst_n);
        while (!halted) begin
            @(posedge clk);
            repeat (3 + rnd(20)) @(posedge clk);
            if (irq_count < MAX_IRQ && !halted && pc < 4 * (HALT_IDX - 12)) begin
                fire_interrupt();
            end
        end
    end

    // Watchdog
    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Timeout after %0d cycles, the core never halted", LIMIT);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [XLEN-1:0] halt_pc;
        @(posedge rst_n);
        while (!halted) begin
            @(posedge clk);
        end
        halt_pc = pc;
        repeat (30) begin
            @(posedge clk);
            if (pc !== halt_pc) begin
                $display("Fail %0t: pc moved to %h after halt at %h", $time, pc, halt_pc);
                data_errors++;
            end
        end
        if (snd_seen != snd_total || snd_expect.size() != 0 || uad_expect.size() != 0) begin
            $display("Error: %0d snd pulses seen, %0d expected, %0d uad missing",
                     snd_seen, snd_total, uad_expect.size());
            other_errors++;
        end
        $display("Errors: %0d data, %0d other, %0d interrupts", data_errors,
                 other_errors, irq_count);
        if (data_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* proc.f */
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/irq_if.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/interrupt_ctrl.sv
rtl/proc.sv
testbench/tb_clock.sv
testbench/tb_proc.sv

/* run.sh */
#!/bin/sh
# Build and run the processor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_proc \
    -f proc.f --Mdir obj_dir -o sim_proc > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_proc > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see sim.log"
exit 1
